//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- design/rv_alu.sv
`timescale 1ns/10ps

module rv_alu import rv_core_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output word_t   result
);

    logic        sub;
    word_t       b_inv;
    logic [32:0] sum;
    logic        carry;
    logic        ge_s;
    logic        eq;

    // Five-stage barrel shift to the right, fill selects the arithmetic shift
    function automatic word_t shift_right(input word_t x, input logic [4:0] sh, input logic fill);
        word_t v;
        v = x;
        for (int s = 0; s < 5; s++) begin
            if (sh[s]) begin
                v = (v >> (1 << s)) | (fill ? ~(word_t'('1) >> (1 << s)) : '0);
            end
        end
        return v;
    endfunction

    assign sub   = op inside {alu_sub, alu_lt, alu_ltu, alu_ge, alu_geu};
    assign b_inv = sub ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, b_inv} + {32'b0, sub};
    assign carry = sum[32]; // Set when a >= b unsigned
    assign ge_s  = carry ^ a[31] ^ b[31];
    assign eq    = (a == b);

    always_comb begin
        case (op)
            alu_add, alu_sub: result = sum[31:0];
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            alu_sll: result = {<<{shift_right({<<{a}}, b[4:0], 1'b0)}}; // Mirrored right shift
            alu_srl: result = shift_right(a, b[4:0], 1'b0);
            alu_sra: result = shift_right(a, b[4:0], a[31]);
            alu_lt:  result = word_t'(!ge_s);
            alu_ge:  result = word_t'(ge_s);
            alu_ltu: result = word_t'(!carry);
            alu_geu: result = word_t'(carry);
            alu_eq:  result = word_t'(eq);
            alu_ne:  result = word_t'(!eq);
            default: result = '0;
        endcase
    end

endmodule

//--- design/rv_core_pkg.sv
`include "rv_settings.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0]     word_t;
    typedef logic [`RV_REG_BITS-1:0] reg_idx_t;
    typedef logic [3:0]              byte_en_t;

    typedef enum logic [1:0] {ph_fetch, ph_latch, ph_exec, ph_finish} phase_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_lt, alu_ltu, alu_and, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_eq, alu_ne, alu_ge, alu_geu
    } alu_op_e;

    typedef enum logic [3:0] {
        cls_comp, cls_compi, cls_lui, cls_auipc, cls_load,
        cls_store, cls_jal, cls_jalr, cls_branch, cls_none
    } instr_class_e;

    // Encoded like funct3[1:0] of loads and stores
    typedef enum logic [1:0] {sz_byte, sz_half, sz_word} mem_size_e;

    typedef struct packed {mem_size_e size; logic uns; logic active;} ld_kind_t;
    typedef struct packed {mem_size_e size; logic active;} st_kind_t;

endpackage

//--- design/rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    output word_t    mem_addr,
    output logic     mem_re,
    output byte_en_t mem_we,
    output word_t    mem_wdata,
    input  word_t    mem_rdata
);

    word_t    ir, alu_a, alu_b, alu_result, lsu_addr, st_data, ld_value;
    alu_op_e  alu_op;
    st_kind_t st_kind;
    ld_kind_t ld_kind;

    rv_decode_if dec_if ();

    rv_decoder i_decoder (.ir(ir), .dec(dec_if.producer));

    rv_datapath i_datapath (
        .clk(clk), .rst_n(rst_n), .dec(dec_if.consumer), .ir(ir),
        .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .alu_result(alu_result),
        .mem_addr(mem_addr), .mem_re(mem_re), .mem_rdata(mem_rdata),
        .lsu_addr(lsu_addr), .st_data(st_data), .st_kind(st_kind),
        .ld_kind(ld_kind), .ld_value(ld_value)
    );

    rv_alu i_alu (.a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result));

    rv_lsu i_lsu (
        .clk(clk), .rst_n(rst_n), .addr(lsu_addr), .st_data(st_data),
        .st_kind(st_kind), .ld_kind(ld_kind), .mem_rdata(mem_rdata),
        .mem_we(mem_we), .mem_wdata(mem_wdata), .ld_value(ld_value)
    );

endmodule

//--- design/rv_datapath.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module rv_datapath import rv_core_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    rv_decode_if.consumer dec,
    output word_t         ir,
    output word_t         alu_a,
    output word_t         alu_b,
    output alu_op_e       alu_op,
    input  word_t         alu_result,
    output word_t         mem_addr,
    output logic          mem_re,
    input  word_t         mem_rdata,
    output word_t         lsu_addr,
    output word_t         st_data,
    output st_kind_t      st_kind,
    output ld_kind_t      ld_kind,
    input  word_t         ld_value
);

    phase_e phase;
    word_t  pc;
    word_t  tr;   // Address of the current instruction
    logic   br_flag;
    word_t  regs [1:`RV_NUM_REGS-1];
    word_t  rs1_val, rs2_val, rd_data;
    logic   is_load, is_branch, is_link, in_exec, uses_rs1, rd_we, pc_we;

    assign is_load   = (dec.cls == cls_load);
    assign is_branch = (dec.cls == cls_branch);
    assign is_link   = (dec.cls == cls_jal) || (dec.cls == cls_jalr);
    assign in_exec   = (phase == ph_exec);
    assign uses_rs1  = !(dec.cls inside {cls_auipc, cls_jal}); // Those two add to TR

    assign rs1_val = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
    assign rs2_val = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

    assign alu_a  = (phase == ph_fetch) ? pc : (in_exec && uses_rs1) ? rs1_val : tr;
    assign alu_b  = (phase == ph_fetch) ? 32'd4 :
                    (in_exec && dec.cls inside {cls_comp, cls_branch}) ? rs2_val : dec.imm;
    assign alu_op = (in_exec && dec.cls inside {cls_comp, cls_compi, cls_branch}) ?
                    dec.alu_op : alu_add;

    assign mem_addr = (phase == ph_fetch) ? pc : alu_result;
    assign mem_re   = (phase == ph_fetch) || (in_exec && is_load);
    assign lsu_addr = alu_result;
    assign st_data  = rs2_val;
    assign st_kind  = in_exec ? dec.st_kind : '0;
    assign ld_kind  = in_exec ? dec.ld_kind : '0;

    assign rd_we = (dec.rd != '0) &&
                   ((in_exec && dec.cls inside {cls_comp, cls_compi, cls_lui, cls_auipc,
                                                cls_jal, cls_jalr}) ||
                    (phase == ph_finish && is_load));
    // Return address is the PC already advanced in fetch
    assign rd_data = is_load ? ld_value : is_link ? pc : alu_result;
    assign pc_we   = (phase == ph_fetch) || (in_exec && is_link) ||
                     (phase == ph_finish && is_branch && br_flag);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase   <= ph_fetch;
            pc      <= `RV_RESET_PC;
            tr      <= '0;
            ir      <= '0;
            br_flag <= 1'b0;
        end else begin
            case (phase)
                ph_fetch: phase <= ph_latch;
                ph_latch: phase <= ph_exec;
                ph_exec:  phase <= (is_load || is_branch) ? ph_finish : ph_fetch;
                default:  phase <= ph_fetch;
            endcase
            if (pc_we) pc <= {alu_result[31:1], 1'b0}; // JALR clears bit 0
            if (phase == ph_fetch) tr <= pc;
            if (phase == ph_latch) ir <= mem_rdata;
            if (in_exec && is_branch) br_flag <= alu_result[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we) begin
            regs[dec.rd] <= rd_data;
        end
    end

endmodule

//--- design/rv_decode_if.sv
`timescale 1ns/10ps

interface rv_decode_if import rv_core_pkg::*; ();

    instr_class_e cls;
    reg_idx_t     rd;
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    word_t        imm;
    alu_op_e      alu_op;
    ld_kind_t     ld_kind;
    st_kind_t     st_kind;

    modport producer (output cls, rd, rs1, rs2, imm, alu_op, ld_kind, st_kind);

    modport consumer (input cls, rd, rs1, rs2, imm, alu_op, ld_kind, st_kind);

endinterface

//--- design/rv_decoder.sv
`timescale 1ns/10ps

module rv_decoder
    import rv_core_pkg::*;
    import rv_isa_pkg::*;
(
    input  word_t         ir,
    rv_decode_if.producer dec
);

    opcode_e opcode;
    funct3_t funct3;
    funct7_t funct7;
    word_t   imm_i, imm_s, imm_b, imm_j, imm_u;

    assign opcode = opcode_e'(ir[6:0]);
    assign funct3 = ir[14:12];
    assign funct7 = ir[31:25];

    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
    assign imm_u = {ir[31:12], 12'b0};

    // Register and immediate ALU ops; returns 0 for an illegal funct7
    function automatic logic arith_op(input funct3_t f3, input funct7_t f7,
                                      input logic is_reg, output alu_op_e op);
        logic base;
        logic alt;
        base = (f7 == f7_base);
        alt  = (f7 == f7_alt);
        op = alu_add;
        arith_op = !is_reg || base;
        case (f3)
            f3_add_sub: begin
                op = (is_reg && alt) ? alu_sub : alu_add;
                arith_op = !is_reg || base || alt;
            end
            f3_sll: begin
                op = alu_sll;
                arith_op = base; // SLLI shamt field sits in funct7 too
            end
            f3_slt:  op = alu_lt;
            f3_sltu: op = alu_ltu;
            f3_xor:  op = alu_xor;
            f3_or:   op = alu_or;
            f3_and:  op = alu_and;
            default: begin
                op = alt ? alu_sra : alu_srl;
                arith_op = base || alt;
            end
        endcase
    endfunction

    always_comb begin
        alu_op_e op;
        logic    ok;
        op = alu_add;
        ok = 1'b0;
        dec.cls     = cls_none;
        dec.rd      = '0;
        dec.rs1     = '0;
        dec.rs2     = '0;
        dec.imm     = '0;
        dec.alu_op  = alu_add;
        dec.ld_kind = '0;
        dec.st_kind = '0;
        case (opcode)
            opc_op: begin
                ok = arith_op(funct3, funct7, 1'b1, op);
                if (ok) begin
                    dec.cls    = cls_comp;
                    dec.rd     = ir[11:7];
                    dec.rs1    = ir[19:15];
                    dec.rs2    = ir[24:20];
                    dec.alu_op = op;
                end
            end
            opc_op_imm: begin
                ok = arith_op(funct3, funct7, 1'b0, op);
                if (ok) begin
                    dec.cls    = cls_compi;
                    dec.rd     = ir[11:7];
                    dec.rs1    = ir[19:15];
                    dec.imm    = imm_i;
                    dec.alu_op = op;
                end
            end
            opc_lui, opc_auipc: begin
                dec.cls = (opcode == opc_lui) ? cls_lui : cls_auipc;
                dec.rd  = ir[11:7];
                dec.imm = imm_u;
            end
            opc_load: begin
                if (funct3[1:0] != 2'b11 && funct3 != 3'b110) begin
                    dec.cls            = cls_load;
                    dec.rd             = ir[11:7];
                    dec.rs1            = ir[19:15];
                    dec.imm            = imm_i;
                    dec.ld_kind.size   = mem_size_e'(funct3[1:0]);
                    dec.ld_kind.uns    = funct3[2];
                    dec.ld_kind.active = 1'b1;
                end
            end
            opc_store: begin
                if (funct3[2] == 1'b0 && funct3[1:0] != 2'b11) begin
                    dec.cls            = cls_store;
                    dec.rs1            = ir[19:15];
                    dec.rs2            = ir[24:20];
                    dec.imm            = imm_s;
                    dec.st_kind.size   = mem_size_e'(funct3[1:0]);
                    dec.st_kind.active = 1'b1;
                end
            end
            opc_jal: begin
                dec.cls = cls_jal;
                dec.rd  = ir[11:7];
                dec.imm = imm_j;
            end
            opc_jalr: begin
                if (funct3 == '0) begin
                    dec.cls = cls_jalr;
                    dec.rd  = ir[11:7];
                    dec.rs1 = ir[19:15];
                    dec.imm = imm_i;
                end
            end
            opc_branch: begin
                ok = 1'b1;
                case (funct3)
                    f3_beq:  op = alu_eq;
                    f3_bne:  op = alu_ne;
                    f3_blt:  op = alu_lt;
                    f3_bge:  op = alu_ge;
                    f3_bltu: op = alu_ltu;
                    f3_bgeu: op = alu_geu;
                    default: ok = 1'b0;
                endcase
                if (ok) begin
                    dec.cls    = cls_branch;
                    dec.rs1    = ir[19:15];
                    dec.rs2    = ir[24:20];
                    dec.imm    = imm_b;
                    dec.alu_op = op;
                end
            end
            default: ; // SYSTEM and unknown opcodes run as no-ops
        endcase
    end

endmodule

//--- design/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_system = 7'b1110011
    } opcode_e;

    localparam funct3_t f3_add_sub = 3'b000;
    localparam funct3_t f3_sll     = 3'b001;
    localparam funct3_t f3_slt     = 3'b010;
    localparam funct3_t f3_sltu    = 3'b011;
    localparam funct3_t f3_xor     = 3'b100;
    localparam funct3_t f3_srl_sra = 3'b101;
    localparam funct3_t f3_or      = 3'b110;
    localparam funct3_t f3_and     = 3'b111;

    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

    localparam funct7_t f7_base = 7'b0000000;
    localparam funct7_t f7_alt  = 7'b0100000; // SUB and SRA

endpackage

//--- design/rv_lsu.sv
`timescale 1ns/10ps

module rv_lsu import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    addr,
    input  word_t    st_data,
    input  st_kind_t st_kind,
    input  ld_kind_t ld_kind,
    input  word_t    mem_rdata,
    output byte_en_t mem_we,
    output word_t    mem_wdata,
    output word_t    ld_value
);

    ld_kind_t   ld_kind_q;
    logic [1:0] ld_off_q;
    word_t      rdata_sh;

    assign mem_wdata = st_data << {addr[1:0], 3'b000};

    always_comb begin
        mem_we = '0;
        if (st_kind.active) begin
            case (st_kind.size)
                sz_byte: mem_we = 4'b0001 << addr[1:0];
                sz_half: mem_we = 4'b0011 << addr[1:0];
                default: mem_we = 4'b1111;
            endcase
        end
    end

    // Held for the cycle in which read data returns
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_kind_q <= '0;
            ld_off_q  <= '0;
        end else if (ld_kind.active) begin
            ld_kind_q <= ld_kind;
            ld_off_q  <= addr[1:0];
        end
    end

    assign rdata_sh = mem_rdata >> {ld_off_q, 3'b000};

    always_comb begin
        case (ld_kind_q.size)
            sz_byte: ld_value = {{24{rdata_sh[7] & !ld_kind_q.uns}}, rdata_sh[7:0]};
            sz_half: ld_value = {{16{rdata_sh[15] & !ld_kind_q.uns}}, rdata_sh[15:0]};
            default: ld_value = rdata_sh;
        endcase
    end

endmodule

//--- design/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Address of the first fetch after reset
`define RV_RESET_PC 32'h1000

// Data and address width
`define RV_XLEN 32

// Register file geometry, x0 included
`define RV_NUM_REGS 32
`define RV_REG_BITS 5

`endif

//--- src.f
+incdir+design
design/rv_isa_pkg.sv
design/rv_core_pkg.sv
design/rv_decode_if.sv
design/rv_decoder.sv
design/rv_alu.sv
design/rv_lsu.sv
design/rv_datapath.sv
design/rv_core_top.sv
tests/rv_core_asserts.sv
tests/tb_checker.sv
tests/tb_top.sv

//--- tests/rv_core_asserts.sv
`timescale 1ns/10ps

module rv_core_asserts import rv_core_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     mem_re,
    input byte_en_t mem_we
);

    int fail_count = 0;

    no_write_on_read: assert property (@(posedge clk) disable iff (!rst_n)
        mem_re |-> (mem_we == '0))
        else begin fail_count++; $error("byte write enables active during a read strobe"); end

    // Byte, aligned half or full word only
    legal_lanes: assert property (@(posedge clk) disable iff (!rst_n)
        mem_we inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111})
        else begin fail_count++; $error("byte write enables form an illegal lane pattern"); end

    no_back_to_back_reads: assert property (@(posedge clk) disable iff (!rst_n)
        mem_re |=> !mem_re)
        else begin fail_count++; $error("two read strobes in adjacent cycles"); end

endmodule

//--- tests/tb_checker.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module tb_checker import rv_core_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input word_t    mem_addr,
    input logic     mem_re,
    input byte_en_t mem_we,
    input word_t    mem_wdata,
    input word_t    mem_rdata
);

    typedef enum logic [2:0] {st_fetch, st_instr, st_store, st_ld_req, st_ld_data} chk_state_e;

    chk_state_e state;
    word_t      x [0:31];
    word_t      pc, ld_addr, st_addr, st_data_exp;
    byte_en_t   st_we_exp;
    logic [2:0] ld_f3;
    reg_idx_t   ld_rd;
    int         gap, gap_exp;
    int         fetch_count = 0;
    int         error_count = 0;

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            error_count++;
            $display("FAIL %s: got %h expected %h (model pc %h)", name, got, exp, pc);
        end
    endtask

    function automatic word_t compute(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return word_t'($signed(a) < $signed(b));
            3'd3:    return word_t'(a < b);
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // One instruction of the ISA model; loads and stores finish on the bus
    task automatic execute(input word_t ins);
        word_t      a, b, imm_i, res, cur;
        logic [2:0] f3;
        logic       wr, taken;
        a     = x[ins[19:15]];
        b     = x[ins[24:20]];
        f3    = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        cur   = pc;
        pc    = pc + 4;
        wr    = 1'b1;
        res   = '0;
        gap_exp = 3;
        state = st_fetch;
        case (ins[6:0])
            7'h33: res = compute(f3, ins[30], a, b);
            7'h13: res = compute(f3, ins[30] && f3 == 3'd5, a, imm_i);
            7'h37: res = {ins[31:12], 12'b0};
            7'h17: res = cur + {ins[31:12], 12'b0};
            7'h6f: begin
                res = cur + 4;
                pc  = cur + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'h67: begin
                res = cur + 4;
                pc  = (a + imm_i) & ~32'd1;
            end
            7'h63: begin
                wr = 1'b0;
                gap_exp = 4;
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = $signed(a) < $signed(b);
                    3'd5:    taken = $signed(a) >= $signed(b);
                    3'd6:    taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken) pc = cur + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            7'h03: begin
                wr = 1'b0;
                gap_exp = 4;
                ld_addr = a + imm_i;
                ld_f3 = f3;
                ld_rd = ins[11:7];
                state = st_ld_req;
            end
            7'h23: begin
                wr = 1'b0;
                st_addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                st_data_exp = b << (8 * st_addr[1:0]);
                case (f3[1:0])
                    2'd0:    st_we_exp = 4'b0001 << st_addr[1:0];
                    2'd1:    st_we_exp = 4'b0011 << st_addr[1:0];
                    default: st_we_exp = 4'b1111;
                endcase
                state = st_store;
            end
            default: wr = 1'b0; // No-op
        endcase
        if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = res;
    endtask

    function automatic word_t extend(input word_t raw, input logic [1:0] off, input logic [2:0] f3);
        word_t v;
        v = raw >> (8 * off);
        case (f3)
            3'd0:    return {{24{v[7]}}, v[7:0]};
            3'd1:    return {{16{v[15]}}, v[15:0]};
            3'd4:    return {24'b0, v[7:0]};
            3'd5:    return {16'b0, v[15:0]};
            default: return v;
        endcase
    endfunction

    always @(posedge clk) begin
        word_t mask;
        if (mem_we != '0 && !(rst_n && state == st_store)) begin
            error_count++;
            $display("Error: byte write enables active outside a store at model pc %h", pc);
        end
        if (!rst_n) begin
            state = st_fetch;
            pc    = `RV_RESET_PC;
            gap   = -1;
            gap_exp = 3;
            for (int i = 0; i < 32; i++) x[i] = '0;
        end else begin
            if (gap >= 0) gap++;
            case (state)
                st_fetch: if (mem_re) begin
                    check_value("mem_addr", mem_addr, pc);
                    if (gap >= 0 && gap != gap_exp) begin
                        error_count++;
                        $display("Error: fetch came %0d cycles after the last, expected %0d",
                                 gap, gap_exp);
                    end
                    gap = 0;
                    fetch_count++;
                    state = st_instr;
                end
                st_instr: execute(mem_rdata);
                st_store: begin
                    mask = {{8{st_we_exp[3]}}, {8{st_we_exp[2]}}, {8{st_we_exp[1]}},
                            {8{st_we_exp[0]}}};
                    check_value("mem_addr", mem_addr, st_addr);
                    check_value("mem_we", word_t'(mem_we), word_t'(st_we_exp));
                    check_value("mem_wdata", mem_wdata & mask, st_data_exp & mask);
                    state = st_fetch;
                end
                st_ld_req: begin
                    if (!mem_re) begin
                        error_count++;
                        $display("Error: load at model pc %h issued no read strobe", pc);
                    end
                    check_value("mem_addr", mem_addr, ld_addr);
                    state = st_ld_data;
                end
                default: begin
                    if (ld_rd != '0) x[ld_rd] = extend(mem_rdata, ld_addr[1:0], ld_f3);
                    state = st_fetch;
                end
            endcase
        end
    end

endmodule

//--- tests/tb_top.sv
`timescale 1ns/10ps
`include "rv_settings.svh"

module tb_top import rv_core_pkg::*; ();

    localparam int RESET_CYCLES = 5;
    localparam int NUM_FETCHES  = 400;
    localparam int NUM_INSTR    = 300;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_FETCHES * 4) * 8 + 2000;

    logic       clk;
    logic       rst_n;
    word_t      mem_addr, mem_wdata, mem_rdata, rdata_q;
    logic       mem_re;
    byte_en_t   mem_we;
    logic [7:0] mem [0:4095];
    word_t      seed;
    int         errs;

    rv_core_top i_dut (
        .clk(clk), .rst_n(rst_n), .mem_addr(mem_addr), .mem_re(mem_re),
        .mem_we(mem_we), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

    tb_checker i_checker (
        .clk(clk), .rst_n(rst_n), .mem_addr(mem_addr), .mem_re(mem_re),
        .mem_we(mem_we), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

    bind rv_core_top rv_core_asserts i_asserts (.*);

    always #4 clk = ~clk;

    // Data in the low 2 KiB and program above the reset PC
    function automatic int mem_index(input word_t a);
        return int'({a[12], a[10:0]});
    endfunction

    function automatic word_t xorshift(input word_t s);
        word_t v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    always @(posedge clk) begin
        int base;
        base = mem_index({mem_addr[31:2], 2'b00});
        if (mem_re) rdata_q <= {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
        for (int k = 0; k < 4; k++) begin
            if (mem_we[k]) mem[base + k] <= mem_wdata[8 * k +: 8];
        end
    end

    always @(negedge clk) mem_rdata <= rdata_q;

    task automatic write_word(input int idx, input word_t w);
        int base;
        base = mem_index(`RV_RESET_PC + 32'(idx * 4));
        for (int k = 0; k < 4; k++) mem[base + k] = w[8 * k +: 8];
    endtask

    task automatic gen_program();
        word_t       r, r2;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [11:0] off;
        logic [20:0] jimm;
        logic [12:0] bimm;
        int          max_k, k;
        write_word(0, {20'h00001, 5'd31, 7'h37}); // LUI x31 to the program base
        for (int i = 1; i < NUM_INSTR - 1; i++) begin
            seed = xorshift(seed);
            r = seed;
            seed = xorshift(seed);
            r2 = seed;
            rd = 5'(r[11:7] % 5'd31);
            f3 = r[14:12];
            max_k = (NUM_INSTR - 1 - i < 8) ? NUM_INSTR - 1 - i : 8;
            k = 1 + int'(r2[23:16]) % max_k;
            off = 12'h100 + {1'b0, 9'(r2[8:0] % 9'd448), 2'b00};
            bimm = 13'(k * 4);
            jimm = 21'(k * 4);
            case (r[31:28] % 4'd10)
                0, 1: write_word(i, {((f3 == 0 || f3 == 5) && r2[0]) ? 7'h20 : 7'h00,
                                     r[24:20], r[19:15], f3, rd, 7'h33});
                2, 3: begin
                    if (f3 == 3'd1) off = {7'h00, r2[4:0]};
                    else if (f3 == 3'd5) off = {r2[5] ? 7'h20 : 7'h00, r2[4:0]};
                    else off = r2[11:0];
                    write_word(i, {off, r[19:15], f3, rd, 7'h13});
                end
                4: write_word(i, {r2[19:0], rd, r2[20] ? 7'h37 : 7'h17});
                5: begin
                    if (f3[1:0] == 2'd3) f3[1:0] = 2'd2;
                    if (f3 == 3'd6) f3 = 3'd2;
                    off[1:0] = (f3[1:0] == 2'd0) ? r2[31:30] :
                               (f3[1:0] == 2'd1) ? {r2[31], 1'b0} : 2'b00;
                    write_word(i, {off, 5'd0, f3, rd, 7'h03});
                end
                6: begin
                    f3 = {1'b0, (r[13:12] == 2'd3) ? 2'd2 : r[13:12]};
                    off[1:0] = (f3[1:0] == 2'd0) ? r2[31:30] :
                               (f3[1:0] == 2'd1) ? {r2[31], 1'b0} : 2'b00;
                    write_word(i, {off[11:5], r[24:20], 5'd0, f3, off[4:0], 7'h23});
                end
                7: begin
                    if (f3[2:1] == 2'b01) f3[2] = 1'b1; // No funct3 2 or 3 for branches
                    write_word(i, {bimm[12], bimm[10:5], r[24:20], r[19:15], f3,
                                   bimm[4:1], bimm[11], 7'h63});
                end
                8: write_word(i, {jimm[20], jimm[10:1], jimm[11], jimm[19:12], rd, 7'h6f});
                default: begin
                    off = 12'((i + k) * 4) | {11'b0, r2[24]}; // Odd target tests bit 0 clear
                    write_word(i, {off, 5'd31, 3'b000, rd, 7'h67});
                end
            endcase
        end
        write_word(NUM_INSTR - 1, 32'h0000006f); // JAL to self
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        mem_rdata = '0;
        rdata_q = '0;
        seed = 32'h61e7;
        for (int i = 0; i < 4096; i++) mem[i] = 8'((i * 8'h9d) ^ (i >> 5));
        gen_program();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        while (i_checker.fetch_count < NUM_FETCHES) @(negedge clk);
        errs = i_checker.error_count + i_dut.i_asserts.fail_count;
        $display("Errors: %0d checker, %0d assertion, after %0d fetches",
                 i_checker.error_count, i_dut.i_asserts.fail_count, i_checker.fetch_count);
        if (errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS * 1ns);
        $display("Timeout: the core did not reach %0d fetches in time", NUM_FETCHES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
